// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module memSubsystem_tb -f sim.f
	./obj_dir/VmemSubsystem_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "simulation did not pass"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/memSubsystem_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_consts.svh"

module memSubsystem_assertions (
	input logic CLK,
	input logic arstN,
	input logic ready,
	input logic cpuCredit,
	input logic ioCredit,
	input logic cpuReqValid,
	input logic ioReqValid,
	input logic busReqN,
	input logic addrOe
);

	// credits a client holds, handed out by the port and spent by a request
	logic [`PORT_CNT_W:0] cpuHeld;
	logic [`PORT_CNT_W:0] ioHeld;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			cpuHeld <= '0;
			ioHeld <= '0;
		end else if (!ready) begin
			// leaving the run state throws every credit away
			cpuHeld <= '0;
			ioHeld <= '0;
		end else begin
			cpuHeld <= cpuHeld + {{`PORT_CNT_W{1'b0}}, cpuCredit} - {{`PORT_CNT_W{1'b0}}, cpuReqValid};
			ioHeld <= ioHeld + {{`PORT_CNT_W{1'b0}}, ioCredit} - {{`PORT_CNT_W{1'b0}}, ioReqValid};
		end
	end

	cpuCreditLimit: assert property (@(posedge CLK) disable iff (!arstN)
		cpuHeld <= `PORT_DEPTH)
		else $error("cpu client holds more credits than the port has FIFO entries");

	ioCreditLimit: assert property (@(posedge CLK) disable iff (!arstN)
		ioHeld <= `PORT_DEPTH)
		else $error("io client holds more credits than the port has FIFO entries");

	// the address bus is only driven while the board bus is still requested
	addrOeNeedsBus: assert property (@(posedge CLK) disable iff (!arstN) busReqN |-> !addrOe)
		else $error("addrOe is high while busReqN is high");

endmodule

bind memSubsystem memSubsystem_assertions uAssertions (
	.CLK(CLK), .arstN(arstN), .ready(ready), .cpuCredit(cpuCredit), .ioCredit(ioCredit),
	.cpuReqValid(cpuReqValid), .ioReqValid(ioReqValid),
	.busReqN(busReqN), .addrOe(addrOe)
);

`default_nettype wire

// ==== bench/memSubsystem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_consts.svh"

module memSubsystem_tb;

	import memPkg::*;

	// eClk toggles every E_HALF cycles, so one refresh period is PERIOD_CYC cycles
	localparam int E_HALF = 5;
	localparam int PERIOD_FALLS = `REF_TC + 1;
	localparam int PERIOD_CYC = PERIOD_FALLS * 2 * E_HALF;
	// the NMI startup is the longest one, four steps of INIT_PERIODS
	localparam int STARTUP_CYC = 4 * `INIT_PERIODS * PERIOD_CYC;
	localparam int FILL_N = 2 ** (`MEM_ADDR_W - 1);
	localparam int RAND_N = 300;
	localparam int HEAVY_N = 300;
	localparam int REF_N = 3;
	localparam int TXNS = 2 * (FILL_N + 2 * RAND_N + HEAVY_N);
	localparam int LIMIT_CYC = 3 * (STARTUP_CYC + 2 * PERIOD_CYC) + 8 * TXNS +
		2 * (REF_N + 2) * PERIOD_CYC + 1000;

	logic CLK = 1'b0;
	logic arstN;
	logic eClk;
	logic resetInN;
	logic nmiInN;
	logic cpuReqValid;
	logic ioReqValid;
	portReq_s cpuReq;
	portReq_s ioReq;
	logic cpuCredit;
	logic ioCredit;
	logic cpuRspValid;
	logic ioRspValid;
	logic [`MEM_DATA_W-1:0] cpuRdata;
	logic [`MEM_DATA_W-1:0] ioRdata;
	logic sysResetN;
	logic busReqN;
	logic addrOe;
	logic [`REF_ROW_W-1:0] refRow;

	// shadow of the array, written in issue order, each port owns one half of it
	logic [`MEM_DATA_W-1:0] shadow [2 ** `MEM_ADDR_W];
	logic [`MEM_DATA_W-1:0] cpuExp [$];
	logic [`MEM_DATA_W-1:0] ioExp [$];
	int creditsGot [2];
	int sent [2];
	int eFalls;
	logic [31:0] rng;

	memSubsystem uut (
		.CLK(CLK), .arstN(arstN), .eClk(eClk), .resetInN(resetInN), .nmiInN(nmiInN),
		.cpuReqValid(cpuReqValid), .ioReqValid(ioReqValid), .cpuReq(cpuReq), .ioReq(ioReq),
		.cpuCredit(cpuCredit), .ioCredit(ioCredit), .cpuRspValid(cpuRspValid),
		.ioRspValid(ioRspValid), .cpuRdata(cpuRdata), .ioRdata(ioRdata),
		.sysResetN(sysResetN), .busReqN(busReqN), .addrOe(addrOe), .refRow(refRow)
	);

	always #10 CLK = ~CLK;

	task automatic abortRun();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkEq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
			abortRun();
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// every address bit shows up in both bytes of the fill word
	function automatic logic [`MEM_DATA_W-1:0] fillWord(input logic [`MEM_ADDR_W-1:0] addr);
		return {addr ^ 8'ha5, ~{addr[3:0], addr[7:4]}};
	endfunction

	// a read returns the last value written to that address before the read was issued
	function automatic logic [`MEM_DATA_W-1:0] expectedRead(input logic [`MEM_ADDR_W-1:0] addr);
		return shadow[addr];
	endfunction

	// E is only stepped once the DUT is out of reset, so fall n lines up with timer step n
	initial begin
		wait (arstN === 1'b1);
		forever begin
			repeat (E_HALF) @(posedge CLK);
			#1 eClk = ~eClk;
			if (!eClk) eFalls++;
		end
	end

	// credits and read data are counted and compared half a cycle after they change
	always @(negedge CLK) begin
		if (!sysResetN) begin
			creditsGot[0] = 0;
			creditsGot[1] = 0;
		end else begin
			if (cpuCredit) creditsGot[0]++;
			if (ioCredit) creditsGot[1]++;
		end
		if (cpuRspValid) begin
			if (cpuExp.size() == 0) begin
				$display("cpu port returned read data with no read outstanding");
				abortRun();
			end else begin
				checkEq("cpu read data", cpuExp.pop_front(), cpuRdata);
			end
		end
		if (ioRspValid) begin
			if (ioExp.size() == 0) begin
				$display("io port returned read data with no read outstanding");
				abortRun();
			end else begin
				checkEq("io read data", ioExp.pop_front(), ioRdata);
			end
		end
	end

	// count requests per port, mode 0 fills the array, 1 is sparse random, 2 is back to back
	task automatic pump(input int count, input int mode);
		int issued [2];
		int p;
		logic send [2];
		portReq_s req [2];
		issued[0] = 0;
		issued[1] = 0;
		while (issued[0] < count || issued[1] < count) begin
			@(posedge CLK);
			#1;
			for (p = 0; p < 2; p++) begin
				rng = xorshift(rng);
				send[p] = (issued[p] < count) && (creditsGot[p] > sent[p]) &&
					(mode != 1 || rng[8]);
				if (mode == 0) begin
					req[p].write = 1'b1;
					req[p].addr = {p[0], issued[p][`MEM_ADDR_W-2:0]};
					req[p].wdata = fillWord(req[p].addr);
				end else begin
					req[p].write = rng[0];
					req[p].addr = {p[0], rng[`MEM_ADDR_W-1:1]};
					req[p].wdata = rng[31:16];
				end
				if (send[p]) begin
					if (req[p].write) begin
						shadow[req[p].addr] = req[p].wdata;
					end else if (p == 0) begin
						cpuExp.push_back(expectedRead(req[p].addr));
					end else begin
						ioExp.push_back(expectedRead(req[p].addr));
					end
					sent[p]++;
					issued[p]++;
				end
			end
			cpuReq = req[0];
			cpuReqValid = send[0];
			ioReq = req[1];
			ioReqValid = send[1];
		end
		@(posedge CLK);
		#1;
		cpuReqValid = 1'b0;
		ioReqValid = 1'b0;
	endtask

	// reads must all come back and every credit must return, a stray extra one shows up later
	task automatic drain(input string name);
		int guard;
		guard = 0;
		while (cpuExp.size() != 0 || ioExp.size() != 0 ||
			creditsGot[0] < sent[0] + `PORT_DEPTH || creditsGot[1] < sent[1] + `PORT_DEPTH) begin
			@(posedge CLK);
			guard++;
			if (guard > 4 * PERIOD_CYC) begin
				$display("%s did not drain, reads or credits are still missing", name);
				abortRun();
			end
		end
		repeat (10) @(negedge CLK);
		checkEq({name, " cpu credits"}, sent[0] + `PORT_DEPTH, creditsGot[0]);
		checkEq({name, " io credits"}, sent[1] + `PORT_DEPTH, creditsGot[1]);
	endtask

	// one power-up sequence, counted in refresh periods from the call until reset releases
	task automatic runStartup(input string name, input int expPeriods, input bit nmiCase);
		int startPeriod;
		int guard;
		bit busDropped;
		bit oeSeen;
		startPeriod = eFalls / PERIOD_FALLS;
		guard = 0;
		busDropped = 1'b0;
		oeSeen = 1'b0;
		sent[0] = 0;
		sent[1] = 0;
		while (sysResetN !== 1'b1) begin
			@(negedge CLK);
			if (busReqN) busDropped = 1'b1;
			if (addrOe && !sysResetN) oeSeen = 1'b1;
			guard++;
			if (guard > STARTUP_CYC + 2 * PERIOD_CYC) begin
				$display("%s never released sysResetN", name);
				abortRun();
			end
		end
		checkEq({name, " periods"}, expPeriods, eFalls / PERIOD_FALLS - startPeriod);
		checkEq({name, " bus released"}, nmiCase, busDropped);
		checkEq({name, " address enable"}, !nmiCase, oeSeen);
		// after ready the port hands out its whole depth, one credit per cycle
		repeat (20) @(negedge CLK);
		checkEq({name, " cpu credits"}, `PORT_DEPTH, creditsGot[0]);
		checkEq({name, " io credits"}, `PORT_DEPTH, creditsGot[1]);
	endtask

	// sample refRow in state 0 of a period, where no refresh can be in flight
	task automatic measureRefresh(input string name, input int periods);
		int target;
		logic [`REF_ROW_W-1:0] rowStart;
		target = (eFalls / PERIOD_FALLS + 1) * PERIOD_FALLS;
		wait (eFalls >= target);
		repeat (6) @(negedge CLK);
		rowStart = refRow;
		wait (eFalls >= target + periods * PERIOD_FALLS);
		repeat (6) @(negedge CLK);
		checkEq(name, `REF_ROW_W'(rowStart + periods), refRow);
	endtask

	// the press lands mid-period, so the restart count of periods is exact
	task automatic pressReset();
		wait (eFalls % PERIOD_FALLS == 5);
		@(posedge CLK);
		#1 resetInN = 1'b0;
		repeat (4) @(posedge CLK);
		#1 resetInN = 1'b1;
		checkEq("reset button", 0, sysResetN);
	endtask

	initial begin
		repeat (LIMIT_CYC) @(posedge CLK);
		$display("watchdog expired after %0d cycles, the DUT stopped making progress",
			LIMIT_CYC);
		abortRun();
	end

	initial begin
		int base;
		arstN = 1'b0;
		eClk = 1'b0;
		resetInN = 1'b1;
		nmiInN = 1'b1;
		cpuReqValid = 1'b0;
		ioReqValid = 1'b0;
		cpuReq = '0;
		ioReq = '0;
		eFalls = 0;
		sent[0] = 0;
		sent[1] = 0;
		rng = 32'hb411;
		repeat (5) @(posedge CLK);
		#1 arstN = 1'b1;
		runStartup("startup", 3 * `INIT_PERIODS, 1'b0);
		pump(FILL_N, 0);
		pump(RAND_N, 1);
		drain("random traffic");
		measureRefresh("refresh idle", REF_N);
		fork
			pump(HEAVY_N, 2);
			measureRefresh("refresh under traffic", REF_N);
		join
		drain("heavy traffic");
		pressReset();
		runStartup("restart", 3 * `INIT_PERIODS, 1'b0);
		pump(RAND_N, 1);
		drain("traffic after restart");
		// NMI is held across the second startup step and released before the third
		pressReset();
		base = eFalls / PERIOD_FALLS;
		fork
			runStartup("nmi startup", 4 * `INIT_PERIODS, 1'b1);
			begin
				wait (eFalls >= (base + `INIT_PERIODS + 1) * PERIOD_FALLS + 5);
				@(posedge CLK);
				#1 nmiInN = 1'b0;
				wait (eFalls >= (base + 2 * `INIT_PERIODS + 2) * PERIOD_FALLS + 5);
				@(posedge CLK);
				#1 nmiInN = 1'b1;
			end
		join
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== common/memPkg.sv ====
`default_nettype none
`include "mem_consts.svh"

package memPkg;

	// what the arbiter is asking the array to do
	typedef enum logic {
		kindAccess,
		kindRefresh
	} memKind_e;

	// ordinary read or write, as seen by the array
	typedef struct packed {
		logic write;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] wdata;
	} memAccess_s;

	// the refresh view pads the row out so it overlays the access view bit for bit
	typedef struct packed {
		logic [`MEM_ADDR_W+`MEM_DATA_W-`REF_ROW_W:0] pad;
		logic [`REF_ROW_W-1:0] row;
	} memRefresh_s;

	// one command word, decoded as an access or a refresh depending on kind
	typedef union packed {
		memAccess_s access;
		memRefresh_s refresh;
	} memCmd_u;

	typedef struct packed {
		memKind_e kind;
		logic src;
		memCmd_u cmd;
	} memReq_s;

	// what a client hands to its port
	typedef struct packed {
		logic write;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] wdata;
	} portReq_s;

	// read data on its way back, src picks the port it goes to
	typedef struct packed {
		logic src;
		logic [`MEM_DATA_W-1:0] rdata;
	} memRsp_s;

endpackage

`default_nettype wire

// ==== common/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// array geometry
`define MEM_ADDR_W 8
`define MEM_DATA_W 16

// refresh period timer, stepped once per E fall, 11 states per period
`define REF_TC 10
`define REF_URG_FROM 8
`define REF_TIMER_W 4

// startup step length and I/O priority window, both counted in refresh periods
`define INIT_PERIODS 4
`define INIT_CNT_W 3
`define QOS_PERIODS 15
`define QOS_W 4

// request FIFO depth per port, which is also the number of credits a client may hold
`define PORT_DEPTH 4
`define PORT_PTR_W 2
`define PORT_CNT_W 3

`define REF_ROW_W 8

// client ids carried in the src field
`define SRC_CPU 1'b0
`define SRC_IO 1'b1

`endif

// ==== hw/memArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_consts.svh"

module memArbiter (
	input logic CLK,
	input logic arstN,
	input logic refTick,
	input logic refReq,
	input logic refUrg,
	input logic cpuPending,
	input logic ioPending,
	input memPkg::portReq_s cpuHead,
	input memPkg::portReq_s ioHead,
	input logic arrRspValid,
	input memPkg::memRsp_s arrRsp,
	output logic cpuGrant,
	output logic ioGrant,
	output logic cmdValid,
	output memPkg::memReq_s cmd,
	output logic cpuRspValid,
	output logic ioRspValid,
	output memPkg::memRsp_s rsp,
	output logic [`REF_ROW_W-1:0] refRow
);

	import memPkg::*;

	logic [`QOS_W-1:0] qosCnt;
	logic qosOpen;
	logic refDone;
	logic refWant;
	logic pickRef;
	logic pickCpu;
	logic pickIo;
	portReq_s headSel;
	memReq_s nextCmd;

	assign qosOpen = (qosCnt != '0);

	// one refresh per period, and none on the boundary cycle itself
	// that cycle belongs to the old period and refDone is being cleared
	assign refWant = refReq && !refDone && !refTick;

	// fixed priority, only the order of the two ports depends on the QoS window
	always_comb begin
		pickRef = 1'b0;
		pickCpu = 1'b0;
		pickIo = 1'b0;
		if (refWant && refUrg) begin
			pickRef = 1'b1;
		end else if (qosOpen && ioPending) begin
			pickIo = 1'b1;
		end else if (cpuPending) begin
			pickCpu = 1'b1;
		end else if (ioPending) begin
			pickIo = 1'b1;
		end else if (refWant) begin
			pickRef = 1'b1;
		end
	end

	assign headSel = pickIo ? ioHead : cpuHead;

	// build the command word, the refresh view carries the row, the access view the request
	always_comb begin
		nextCmd = '0;
		if (pickRef) begin
			nextCmd.kind = kindRefresh;
			nextCmd.src = `SRC_CPU;
			nextCmd.cmd.refresh.row = refRow;
		end else begin
			nextCmd.kind = kindAccess;
			nextCmd.src = pickIo ? `SRC_IO : `SRC_CPU;
			nextCmd.cmd.access.write = headSel.write;
			nextCmd.cmd.access.addr = headSel.addr;
			nextCmd.cmd.access.wdata = headSel.wdata;
		end
	end

	// grant and command leave together, one cycle after the port showed pending
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			cpuGrant <= 1'b0;
			ioGrant <= 1'b0;
			cmdValid <= 1'b0;
		end else begin
			cpuGrant <= pickCpu;
			ioGrant <= pickIo;
			cmdValid <= pickRef || pickCpu || pickIo;
		end
	end

	always_ff @(posedge CLK) begin
		cmd <= nextCmd;
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			refDone <= 1'b0;
			qosCnt <= '0;
			refRow <= '0;
		end else begin
			if (refTick) begin
				refDone <= 1'b0;
			end else if (pickRef) begin
				refDone <= 1'b1;
			end
			// every I/O access reopens the window, it then drains one per period
			if (pickIo) begin
				qosCnt <= `QOS_W'(`QOS_PERIODS);
			end else if (refTick && qosOpen) begin
				qosCnt <= qosCnt - 1'b1;
			end
			// row moves on once the refresh has gone out to the array
			if (cmdValid && (cmd.kind == kindRefresh)) refRow <= refRow + 1'b1;
		end
	end

	// read data goes back to whichever port issued it
	assign cpuRspValid = arrRspValid && (arrRsp.src == `SRC_CPU);
	assign ioRspValid = arrRspValid && (arrRsp.src == `SRC_IO);
	assign rsp = arrRsp;

endmodule

`default_nettype wire

// ==== hw/memArray.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_consts.svh"

module memArray (
	input logic CLK,
	input logic arstN,
	input logic cmdValid,
	input memPkg::memReq_s cmd,
	output logic rspValid,
	output memPkg::memRsp_s rsp
);

	import memPkg::*;

	logic [`MEM_DATA_W-1:0] mem [2**`MEM_ADDR_W];
	memAccess_s acc;
	logic isAccess;
	logic doWrite;
	logic doRead;

	// the word only means an access when kind says so
	// a refresh passes through without touching the data
	assign acc = cmd.cmd.access;
	assign isAccess = cmdValid && (cmd.kind == kindAccess);
	assign doWrite = isAccess && acc.write;
	assign doRead = isAccess && !acc.write;

	// the command register in the arbiter is the first stage, this read register the second
	// a write lands at the end of its command cycle
	always_ff @(posedge CLK) begin
		if (doWrite) mem[acc.addr] <= acc.wdata;
		rsp.rdata <= mem[acc.addr];
		rsp.src <= cmd.src;
	end

	// writes are posted, only reads produce a response
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			rspValid <= 1'b0;
		end else begin
			rspValid <= doRead;
		end
	end

endmodule

`default_nettype wire

// ==== hw/memPort.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_consts.svh"

module memPort (
	input logic CLK,
	input logic arstN,
	input logic ready,
	input logic reqValid,
	input memPkg::portReq_s req,
	input logic grant,
	input memPkg::memRsp_s rspIn,
	input logic rspInValid,
	output logic creditOut,
	output logic pending,
	output memPkg::portReq_s head,
	output logic rspValid,
	output logic [`MEM_DATA_W-1:0] rdata
);

	import memPkg::*;

	portReq_s fifo [`PORT_DEPTH];
	logic [`PORT_PTR_W-1:0] wrPtr;
	logic [`PORT_PTR_W-1:0] rdPtr;
	logic [`PORT_PTR_W-1:0] peekPtr;
	logic [`PORT_CNT_W-1:0] count;
	logic [`PORT_CNT_W-1:0] initCnt;
	logic push;
	logic pop;
	logic initCredit;

	// the client only sends while it holds a credit, so a push never finds the FIFO full
	assign push = ready && reqValid;
	assign pop = ready && grant;

	// a pop credit takes the slot, the next initial credit simply waits one cycle
	assign initCredit = ready && !grant && (initCnt != `PORT_CNT_W'(`PORT_DEPTH));
	assign creditOut = pop || initCredit;

	always_ff @(posedge CLK) begin
		if (push) fifo[wrPtr] <= req;
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			initCnt <= '0;
		end else if (!ready) begin
			// sequencer left the run state, drop everything and start the credits over
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			initCnt <= '0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1;
			if (pop) rdPtr <= rdPtr + 1'b1;
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
			if (initCredit) initCnt <= initCnt + 1'b1;
		end
	end

	// while grant is high the arbiter has already taken the head entry
	// so it sees the entry behind it and one entry fewer
	assign peekPtr = rdPtr + `PORT_PTR_W'(grant);
	assign pending = (count > `PORT_CNT_W'(grant));
	assign head = fifo[peekPtr];

	// response register, the last stage of the read path
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			rspValid <= 1'b0;
		end else begin
			rspValid <= rspInValid;
		end
	end

	always_ff @(posedge CLK) begin
		rdata <= rspIn.rdata;
	end

endmodule

`default_nettype wire

// ==== hw/memSubsystem.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_consts.svh"

module memSubsystem (
	input logic CLK,
	input logic arstN,
	input logic eClk,
	input logic resetInN,
	input logic nmiInN,
	input logic cpuReqValid,
	input logic ioReqValid,
	input memPkg::portReq_s cpuReq,
	input memPkg::portReq_s ioReq,
	output logic cpuCredit,
	output logic ioCredit,
	output logic cpuRspValid,
	output logic ioRspValid,
	output logic [`MEM_DATA_W-1:0] cpuRdata,
	output logic [`MEM_DATA_W-1:0] ioRdata,
	output logic sysResetN,
	output logic busReqN,
	output logic addrOe,
	output logic [`REF_ROW_W-1:0] refRow
);

	import memPkg::*;

	logic refTick;
	logic refReq;
	logic refUrg;
	logic initTick;
	logic seqActive;
	logic ready;
	logic cpuPending;
	logic ioPending;
	logic cpuGrant;
	logic ioGrant;
	logic cmdValid;
	logic arrRspValid;
	logic cpuSteer;
	logic ioSteer;
	portReq_s cpuHead;
	portReq_s ioHead;
	memReq_s cmd;
	memRsp_s arrRsp;
	memRsp_s rsp;

	cycleTimer uCycleTimer (
		.CLK(CLK), .arstN(arstN), .eClk(eClk), .seqActive(seqActive),
		.refTick(refTick), .refReq(refReq), .refUrg(refUrg), .initTick(initTick)
	);

	startupSequencer uSequencer (
		.CLK(CLK), .arstN(arstN), .initTick(initTick), .resetInN(resetInN), .nmiInN(nmiInN),
		.sysResetN(sysResetN), .busReqN(busReqN), .addrOe(addrOe), .ready(ready),
		.seqActive(seqActive)
	);

	memPort uCpuPort (
		.CLK(CLK), .arstN(arstN), .ready(ready), .reqValid(cpuReqValid), .req(cpuReq),
		.grant(cpuGrant), .rspIn(rsp), .rspInValid(cpuSteer), .creditOut(cpuCredit),
		.pending(cpuPending), .head(cpuHead), .rspValid(cpuRspValid), .rdata(cpuRdata)
	);

	memPort uIoPort (
		.CLK(CLK), .arstN(arstN), .ready(ready), .reqValid(ioReqValid), .req(ioReq),
		.grant(ioGrant), .rspIn(rsp), .rspInValid(ioSteer), .creditOut(ioCredit),
		.pending(ioPending), .head(ioHead), .rspValid(ioRspValid), .rdata(ioRdata)
	);

	memArbiter uArbiter (
		.CLK(CLK), .arstN(arstN), .refTick(refTick), .refReq(refReq), .refUrg(refUrg),
		.cpuPending(cpuPending), .ioPending(ioPending), .cpuHead(cpuHead), .ioHead(ioHead),
		.arrRspValid(arrRspValid), .arrRsp(arrRsp), .cpuGrant(cpuGrant), .ioGrant(ioGrant),
		.cmdValid(cmdValid), .cmd(cmd), .cpuRspValid(cpuSteer), .ioRspValid(ioSteer),
		.rsp(rsp), .refRow(refRow)
	);

	memArray uArray (
		.CLK(CLK), .arstN(arstN), .cmdValid(cmdValid), .cmd(cmd),
		.rspValid(arrRspValid), .rsp(arrRsp)
	);

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/memPkg.sv
timing/cycleTimer.sv
timing/startupSequencer.sv
hw/memPort.sv
hw/memArbiter.sv
hw/memArray.sv
hw/memSubsystem.sv
bench/memSubsystem_assertions.sv
bench/memSubsystem_tb.sv

// ==== timing/cycleTimer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_consts.svh"

module cycleTimer (
	input logic CLK,
	input logic arstN,
	input logic eClk,
	input logic seqActive,
	output logic refTick,
	output logic refReq,
	output logic refUrg,
	output logic initTick
);

	logic [1:0] eSync;
	logic eLast;
	logic eFall;
	logic tcHit;
	logic [`REF_TIMER_W-1:0] timer;
	logic [`INIT_CNT_W-1:0] initCnt;

	// E is slow and unrelated to CLK, so it goes through two flops first
	// eLast holds the previous synchronized level for the edge detector
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			eSync <= '0;
			eLast <= 1'b0;
		end else begin
			eSync <= {eSync[0], eClk};
			eLast <= eSync[1];
		end
	end

	// high for one cycle, two edges after the pin falls, so the fall acts on the third edge
	assign eFall = eLast && !eSync[1];

	assign tcHit = (timer == `REF_TIMER_W'(`REF_TC));

	// period timer runs 0..REF_TC, one step per E fall
	// the flags are registered from the value the timer is leaving, so they line up
	// with the state being entered
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			timer <= '0;
			refReq <= 1'b0;
			refUrg <= 1'b0;
		end else if (eFall) begin
			if (tcHit) begin
				timer <= '0;
			end else begin
				timer <= timer + 1'b1;
			end
			// request drops only while the timer sits in state 0
			refReq <= !tcHit;
			// urgent over the last two states of the period
			refUrg <= (timer >= `REF_TIMER_W'(`REF_URG_FROM)) && !tcHit;
		end
	end

	// one-cycle marker for the period boundary
	assign refTick = eFall && tcHit;

	// the long timer only runs while the sequencer is still stepping
	// it is parked at zero in the run state so every startup starts from a clean count
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			initCnt <= '0;
		end else if (!seqActive) begin
			initCnt <= '0;
		end else if (refTick) begin
			if (initTick) begin
				initCnt <= '0;
			end else begin
				initCnt <= initCnt + 1'b1;
			end
		end
	end

	assign initTick = seqActive && refTick &&
		(initCnt == `INIT_CNT_W'(`INIT_PERIODS - 1));

endmodule

`default_nettype wire

// ==== timing/startupSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module startupSequencer (
	input logic CLK,
	input logic arstN,
	input logic initTick,
	input logic resetInN,
	input logic nmiInN,
	output logic sysResetN,
	output logic busReqN,
	output logic addrOe,
	output logic ready,
	output logic seqActive
);

	typedef enum logic [1:0] {
		stHold,
		stNmi,
		stAddr,
		stRun
	} seqState_e;

	seqState_e state;
	logic [1:0] resetSync;
	logic [1:0] nmiSync;
	logic nmiHeld;
	logic lookReset;

	// buttons idle high, so the synchronizers come out of reset as released
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			resetSync <= 2'b11;
			nmiSync <= 2'b11;
		end else begin
			resetSync <= {resetSync[0], resetInN};
			nmiSync <= {nmiSync[0], nmiInN};
		end
	end

	assign nmiHeld = !nmiSync[1];

	// arm the reset button only after it has been seen released in the run state
	// otherwise a button still held from power-up would loop the sequence forever
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			lookReset <= 1'b0;
		end else if (state != stRun) begin
			lookReset <= 1'b0;
		end else if (resetSync[1]) begin
			lookReset <= 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= stHold;
			sysResetN <= 1'b0;
			busReqN <= 1'b0;
			addrOe <= 1'b0;
		end else begin
			case (state)
				stHold: begin
					if (initTick) state <= stNmi;
				end
				stNmi: begin
					// once NMI is seen the bus request stays off until the next startup
					if (nmiHeld) busReqN <= 1'b1;
					if (initTick && !nmiHeld) state <= stAddr;
				end
				stAddr: begin
					addrOe <= !busReqN;
					if (initTick) begin
						state <= stRun;
						sysResetN <= 1'b1;
					end
				end
				stRun: begin
					if (lookReset && !resetSync[1]) begin
						state <= stHold;
						sysResetN <= 1'b0;
						busReqN <= 1'b0;
						addrOe <= 1'b0;
					end
				end
				default: state <= stHold;
			endcase
		end
	end

	assign ready = (state == stRun);
	assign seqActive = (state != stRun);

endmodule

`default_nettype wire
